/* hdl/vec_config.svh */
`ifndef VEC_CONFIG_SVH
`define VEC_CONFIG_SVH

// ========================================
// Slice geometry
// ========================================

// Elements handled per cycle by the lane ALUs
`define VEC_NUM_LANES 2

// Bits held by one vector register
`define VEC_VLEN 128

// Vector registers in the file, v0 through v7
`define VEC_NUM_REGS 8

// Width of a lane slot, the widest element supported
`define VEC_ELEN 32

`endif

/* hdl/vec_types_pkg.sv */
`include "vec_config.svh"

package vec_types_pkg;

  // ========================================
  // Element width and operation codes
  // ========================================

  // Selected element width, coded as in the vtype field
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  // Operations the sequencer understands
  typedef enum logic [2:0] {
    VOP_SETVL = 3'd0, // Set vl and sew, no datapath work
    VOP_ADD   = 3'd1,
    VOP_SUB   = 3'd2,
    VOP_AND   = 3'd3,
    VOP_OR    = 3'd4
  } vop_t;

  // ========================================
  // Index and data words
  // ========================================

  // Element index, must reach VLEN/8 itself so vl=16 fits
  typedef logic [$clog2(`VEC_VLEN / 8):0] offset_t;

  // Vector register number
  typedef logic [$clog2(`VEC_NUM_REGS)-1:0] vreg_t;

  // One lane slot; narrower elements sit zero-extended in the low bits
  typedef logic [`VEC_ELEN-1:0] elem_t;

endpackage

/* hdl/element_counter_if.sv */
`timescale 1ns/1ps

interface element_counter_if;

  // Commands from the sequencer control
  logic clear;     // Zero offset and done, wins over everything else
  logic de_en;     // Counter enabled for this cycle
  logic ex_return; // Resume after an interrupted instruction
  logic stall;     // Hold the offset this cycle

  // CSR values routed through to the counter
  vec_types_pkg::offset_t vstart;
  vec_types_pkg::offset_t vl;

  // Counter state
  vec_types_pkg::offset_t offset; // First element of the current group
  logic done;                     // Offset is at or past vl

  modport counter (
    input  clear, de_en, ex_return, stall,
    input  vstart, vl,
    output offset, done
  );

  modport ctrl (
    output clear, de_en, ex_return, stall,
    input  done
  );

endinterface

/* hdl/lane_if.sv */
`timescale 1ns/1ps
`include "vec_config.svh"

interface lane_if;

  // Operand slots read from vs1 and vs2, one per lane
  vec_types_pkg::elem_t src1 [`VEC_NUM_LANES];
  vec_types_pkg::elem_t src2 [`VEC_NUM_LANES];

  // Element index of lane 0; lane i works on element base+i
  vec_types_pkg::offset_t base;

  // Results on their way back to vd
  vec_types_pkg::elem_t result [`VEC_NUM_LANES];
  logic [`VEC_NUM_LANES-1:0] wr_en; // One write strobe per lane

  modport regfile (
    output src1, src2, base,
    input  result, wr_en
  );

  modport alu (
    input  src1, src2, base,
    output result, wr_en
  );

endinterface

/* hdl/element_counter.sv */
`timescale 1ns/1ps
`include "vec_config.svh"

module element_counter (
  input logic CLK,
  input logic nRST,
  element_counter_if.counter ele_if
);

  vec_types_pkg::offset_t next_offset;
  logic next_done;

  // ========================================
  // Next offset
  // ========================================

  always_comb begin
    next_offset = ele_if.offset; // Hold unless told otherwise
    if (ele_if.de_en && ele_if.ex_return) begin
      // Pick up where the interrupted instruction left off
      next_offset = ele_if.vstart;
    end else if (ele_if.de_en && !ele_if.stall) begin
      next_offset = ele_if.offset + vec_types_pkg::offset_t'(`VEC_NUM_LANES);
    end
  end

  // Flag goes up once the group about to be presented has nothing left in it
  assign next_done = (next_offset >= ele_if.vl);

  // ========================================
  // State
  // ========================================

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ele_if.offset <= '0;
      ele_if.done   <= 1'b0;
    end else if (ele_if.clear) begin
      ele_if.offset <= '0; // A new instruction always starts from element 0
      ele_if.done   <= 1'b0;
    end else begin
      ele_if.offset <= next_offset;
      ele_if.done   <= next_done;
    end
  end

endmodule

/* hdl/vec_csr.sv */
`timescale 1ns/1ps
`include "vec_config.svh"

module vec_csr (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   setvl,     // vsetvl being accepted this cycle
  input  vec_types_pkg::offset_t avl,       // Requested application vector length
  input  vec_types_pkg::sew_t    sew_in,    // Requested element width
  input  logic                   vstart_we, // Host write of vstart
  input  vec_types_pkg::offset_t vstart_in,
  input  logic                   op_end,    // Element op completing this cycle
  output vec_types_pkg::offset_t vl,
  output vec_types_pkg::sew_t    sew,
  output vec_types_pkg::offset_t vstart
);

  // Elements per register at SEW8; wider elements halve it per step
  localparam vec_types_pkg::offset_t MAX_ELEMS = vec_types_pkg::offset_t'(`VEC_VLEN / 8);

  vec_types_pkg::offset_t capacity;
  vec_types_pkg::offset_t vl_clamped;

  // ========================================
  // vsetvl clamp
  // ========================================

  always_comb begin
    capacity   = MAX_ELEMS >> sew_in;                    // 16, 8 or 4 elements
    vl_clamped = (avl < capacity) ? avl : capacity;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      vl  <= '0;
      sew <= vec_types_pkg::SEW8;
    end else if (setvl) begin
      vl  <= vl_clamped; // Takes effect on the edge that samples issue
      sew <= sew_in;
    end
  end

  // Completion wins over a host write landing in the same cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      vstart <= '0;
    end else if (op_end) begin
      vstart <= '0;
    end else if (vstart_we) begin
      vstart <= vstart_in;
    end
  end

endmodule

/* hdl/vec_seq_ctrl.sv */
`timescale 1ns/1ps

module vec_seq_ctrl (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  issue,
  input  vec_types_pkg::vop_t   op,
  input  vec_types_pkg::vreg_t  vd,
  input  vec_types_pkg::vreg_t  vs1,
  input  vec_types_pkg::vreg_t  vs2,
  input  logic                  resume,  // Restart from vstart rather than element 0
  input  logic                  stall,   // Writeback back-pressure
  output logic                  busy,
  output logic                  done,
  output logic                  setvl,
  output logic                  op_end,
  output vec_types_pkg::vop_t   run_op,
  output vec_types_pkg::vreg_t  run_vd,
  output vec_types_pkg::vreg_t  run_vs1,
  output vec_types_pkg::vreg_t  run_vs2,
  element_counter_if.ctrl       ele_if
);

  typedef enum logic [1:0] {IDLE, LOAD, RUN, SETVL_ACK} state_t;

  state_t state, next_state;
  logic   accept;   // Ready to sample issue
  logic   start_op; // Element op accepted this cycle

  assign accept   = (state == IDLE) || (state == SETVL_ACK); // busy is low in both
  assign setvl    = accept && issue && (op == vec_types_pkg::VOP_SETVL);
  assign start_op = accept && issue && (op != vec_types_pkg::VOP_SETVL);
  assign op_end   = (state == RUN) && ele_if.done && !stall;
  assign busy     = (state == LOAD) || (state == RUN);

  // ========================================
  // Counter commands
  // ========================================

  assign ele_if.clear     = start_op;
  assign ele_if.de_en     = busy;
  assign ele_if.ex_return = (state == LOAD);
  // The vstart load cycle presents no valid group, so it is held like a stall
  assign ele_if.stall     = stall || (state == LOAD);

  always_comb begin
    next_state = state;
    case (state)
      IDLE, SETVL_ACK: begin
        if (setvl) next_state = SETVL_ACK;
        else if (start_op) next_state = resume ? LOAD : RUN;
        else next_state = IDLE;
      end
      LOAD:    next_state = RUN; // Offset now holds vstart
      RUN:     if (op_end) next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      done  <= 1'b0;
    end else begin
      state <= next_state;
      done  <= setvl || op_end; // One-cycle pulse after either kind of completion
    end
  end

  // Instruction fields stay put for the whole operation
  always_ff @(posedge CLK) begin
    if (start_op) begin
      run_op  <= op;
      run_vd  <= vd;
      run_vs1 <= vs1;
      run_vs2 <= vs2;
    end
  end

endmodule

/* hdl/vec_lane_alu.sv */
`timescale 1ns/1ps
`include "vec_config.svh"

module vec_lane_alu (
  input  vec_types_pkg::vop_t   run_op,
  input  vec_types_pkg::sew_t   sew,
  input  vec_types_pkg::offset_t vl,
  input  logic                  active, // An element op is in flight
  input  logic                  stall,  // No write this cycle
  lane_if.alu                   ln
);

  localparam int NUM_LANES = `VEC_NUM_LANES;

  vec_types_pkg::elem_t mask;

  // Keeps only the bits of the selected element width
  always_comb begin
    case (sew)
      vec_types_pkg::SEW8:  mask = 32'h0000_00ff;
      vec_types_pkg::SEW16: mask = 32'h0000_ffff;
      default:              mask = 32'hffff_ffff;
    endcase
  end

  // ========================================
  // Per-lane datapath
  // ========================================

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    vec_types_pkg::elem_t   raw;
    vec_types_pkg::offset_t lane_idx;

    assign lane_idx = ln.base + vec_types_pkg::offset_t'(i); // Element this lane owns

    always_comb begin
      case (run_op)
        vec_types_pkg::VOP_ADD: raw = ln.src1[i] + ln.src2[i];
        vec_types_pkg::VOP_SUB: raw = ln.src1[i] - ln.src2[i];
        vec_types_pkg::VOP_AND: raw = ln.src1[i] & ln.src2[i];
        vec_types_pkg::VOP_OR:  raw = ln.src1[i] | ln.src2[i];
        default:                raw = '0; // vsetvl never reaches the lanes
      endcase
    end

    // Carries and borrows out of the element drop off here
    assign ln.result[i] = raw & mask;

    // The tail past vl is left undisturbed
    assign ln.wr_en[i] = active && !stall && (lane_idx < vl);
  end

endmodule

/* hdl/vec_regfile.sv */
`timescale 1ns/1ps
`include "vec_config.svh"

module vec_regfile (
  input  logic                   CLK,
  input  logic                   nRST,
  input  vec_types_pkg::vreg_t   run_vd,
  input  vec_types_pkg::vreg_t   run_vs1,
  input  vec_types_pkg::vreg_t   run_vs2,
  input  vec_types_pkg::sew_t    sew,
  input  vec_types_pkg::offset_t offset,     // Element index of the current group
  input  logic                   busy,       // Host writes are refused while set
  input  logic                   host_we,
  input  vec_types_pkg::vreg_t   host_reg,
  input  vec_types_pkg::offset_t host_idx,
  input  vec_types_pkg::elem_t   host_wdata,
  output vec_types_pkg::elem_t   host_rdata,
  lane_if.regfile                ln
);

  localparam int VLEN      = `VEC_VLEN;
  localparam int NUM_REGS  = `VEC_NUM_REGS;
  localparam int NUM_LANES = `VEC_NUM_LANES;

  typedef logic [VLEN-1:0] vbits_t;

  vbits_t regs [NUM_REGS];
  vbits_t wr_image; // vd with this cycle's lane results merged in

  // ========================================
  // Element slicing
  // ========================================

  // Out-of-range indices read as zero
  function automatic vec_types_pkg::elem_t get_elem(vbits_t r, vec_types_pkg::offset_t idx,
                                                    vec_types_pkg::sew_t s);
    vec_types_pkg::elem_t e;
    e = '0;
    case (s)
      vec_types_pkg::SEW8:  if (int'(idx) < VLEN / 8) e = {24'h0, r[int'(idx) * 8 +: 8]};
      vec_types_pkg::SEW16: if (int'(idx) < VLEN / 16) e = {16'h0, r[int'(idx) * 16 +: 16]};
      default:              if (int'(idx) < VLEN / 32) e = r[int'(idx) * 32 +: 32];
    endcase
    return e;
  endfunction

  // Out-of-range indices leave the register unchanged
  function automatic vbits_t put_elem(vbits_t r, vec_types_pkg::offset_t idx,
                                      vec_types_pkg::sew_t s, vec_types_pkg::elem_t e);
    vbits_t v;
    v = r;
    case (s)
      vec_types_pkg::SEW8:  if (int'(idx) < VLEN / 8) v[int'(idx) * 8 +: 8] = e[7:0];
      vec_types_pkg::SEW16: if (int'(idx) < VLEN / 16) v[int'(idx) * 16 +: 16] = e[15:0];
      default:              if (int'(idx) < VLEN / 32) v[int'(idx) * 32 +: 32] = e;
    endcase
    return v;
  endfunction

  // ========================================
  // Lane and host ports
  // ========================================

  assign ln.base = offset;

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_rd
    vec_types_pkg::offset_t idx;
    assign idx        = offset + vec_types_pkg::offset_t'(i);
    assign ln.src1[i] = get_elem(regs[run_vs1], idx, sew);
    assign ln.src2[i] = get_elem(regs[run_vs2], idx, sew);
  end

  always_comb begin
    wr_image = regs[run_vd];
    for (int i = 0; i < NUM_LANES; i++) begin
      if (ln.wr_en[i]) begin
        wr_image = put_elem(wr_image, ln.base + vec_types_pkg::offset_t'(i), sew, ln.result[i]);
      end
    end
  end

  assign host_rdata = get_elem(regs[host_reg], host_idx, sew); // Combinational read

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int r = 0; r < NUM_REGS; r++) regs[r] <= '0;
    end else if (|ln.wr_en) begin
      regs[run_vd] <= wr_image;
    end else if (host_we && !busy) begin
      regs[host_reg] <= put_elem(regs[host_reg], host_idx, sew, host_wdata);
    end
  end

endmodule

/* hdl/vec_seq_top.sv */
`timescale 1ns/1ps

module vec_seq_top (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   issue,
  input  vec_types_pkg::vop_t    op,
  input  vec_types_pkg::vreg_t   vd,
  input  vec_types_pkg::vreg_t   vs1,
  input  vec_types_pkg::vreg_t   vs2,
  input  vec_types_pkg::offset_t avl,
  input  vec_types_pkg::sew_t    sew_in,
  input  logic                   resume,
  input  logic                   stall,
  input  logic                   vstart_we,
  input  vec_types_pkg::offset_t vstart_in,
  input  logic                   host_we,
  input  vec_types_pkg::vreg_t   host_reg,
  input  vec_types_pkg::offset_t host_idx,
  input  vec_types_pkg::elem_t   host_wdata,
  output vec_types_pkg::elem_t   host_rdata,
  output logic                   busy,
  output logic                   done,
  output vec_types_pkg::offset_t vl,
  output vec_types_pkg::sew_t    sew,
  output vec_types_pkg::offset_t vstart
);

  element_counter_if ele_if ();
  lane_if            ln ();

  logic                 setvl;
  logic                 op_end;
  vec_types_pkg::vop_t  run_op;
  vec_types_pkg::vreg_t run_vd;
  vec_types_pkg::vreg_t run_vs1;
  vec_types_pkg::vreg_t run_vs2;

  // CSR values feeding the counter
  assign ele_if.vl     = vl;
  assign ele_if.vstart = vstart;

  vec_seq_ctrl i_ctrl (
    .CLK, .nRST, .issue, .op, .vd, .vs1, .vs2, .resume, .stall,
    .busy, .done, .setvl, .op_end, .run_op, .run_vd, .run_vs1, .run_vs2,
    .ele_if (ele_if.ctrl)
  );

  element_counter i_counter (.CLK, .nRST, .ele_if (ele_if.counter));

  vec_csr i_csr (
    .CLK, .nRST, .setvl, .avl, .sew_in, .vstart_we, .vstart_in, .op_end,
    .vl, .sew, .vstart
  );

  // The internal hold covers the vstart load cycle as well as back-pressure
  vec_lane_alu i_alu (
    .run_op, .sew, .vl, .active (busy), .stall (ele_if.stall), .ln (ln.alu)
  );

  vec_regfile i_regfile (
    .CLK, .nRST, .run_vd, .run_vs1, .run_vs2, .sew, .offset (ele_if.offset), .busy,
    .host_we, .host_reg, .host_idx, .host_wdata, .host_rdata, .ln (ln.regfile)
  );

endmodule

/* bench/vec_seq_tb.sv */
`timescale 1ns/1ps
`include "vec_config.svh"

module vec_seq_tb;

  localparam int PERIOD      = 20;
  localparam int NUM_ROWS    = 13;
  localparam int REG_BYTES   = `VEC_VLEN / 8;
  localparam int STALL_ALLOW = 100; // Longest stretch of back-pressure one row may see
  // Three register loads and one readback of 16 elements, then the run itself
  localparam int ROW_CYCLES  = 4 * 16 + 16 + STALL_ALLOW + 10;
  localparam int WATCHDOG_NS = (NUM_ROWS * ROW_CYCLES + 200) * PERIOD; // 200 covers reset

  typedef struct {
    vec_types_pkg::vop_t op;
    int                  vd;
    int                  vs1;
    int                  vs2;
    int                  avl;
    vec_types_pkg::sew_t sew;
    int                  vstart;
    bit                  resume;
    int                  stall_pct; // Chance of stall per run cycle in percent
    bit                  reissue;   // Fire a second issue while busy
  } row_t;

  // op, vd, vs1, vs2, avl, sew, vstart, resume, stall %, reissue
  row_t rows [NUM_ROWS] = '{
    '{vec_types_pkg::VOP_ADD, 1, 2, 3, 25, vec_types_pkg::SEW8,  0, 1'b0, 0,  1'b0},
    '{vec_types_pkg::VOP_SUB, 4, 5, 6, 5,  vec_types_pkg::SEW8,  0, 1'b0, 0,  1'b0},
    '{vec_types_pkg::VOP_AND, 1, 2, 3, 8,  vec_types_pkg::SEW16, 0, 1'b0, 0,  1'b0},
    '{vec_types_pkg::VOP_OR,  7, 0, 1, 3,  vec_types_pkg::SEW16, 0, 1'b0, 0,  1'b0},
    '{vec_types_pkg::VOP_ADD, 2, 3, 4, 4,  vec_types_pkg::SEW32, 0, 1'b0, 0,  1'b0},
    '{vec_types_pkg::VOP_SUB, 5, 6, 7, 16, vec_types_pkg::SEW32, 0, 1'b0, 0,  1'b0},
    '{vec_types_pkg::VOP_AND, 3, 1, 2, 12, vec_types_pkg::SEW8,  5, 1'b1, 0,  1'b0},
    '{vec_types_pkg::VOP_OR,  6, 4, 5, 6,  vec_types_pkg::SEW16, 6, 1'b1, 0,  1'b0},
    '{vec_types_pkg::VOP_OR,  0, 1, 2, 16, vec_types_pkg::SEW8,  0, 1'b0, 50, 1'b0},
    '{vec_types_pkg::VOP_SUB, 4, 4, 5, 7,  vec_types_pkg::SEW16, 3, 1'b1, 75, 1'b0},
    '{vec_types_pkg::VOP_ADD, 1, 2, 3, 9,  vec_types_pkg::SEW16, 0, 1'b0, 0,  1'b1},
    '{vec_types_pkg::VOP_SUB, 2, 2, 2, 2,  vec_types_pkg::SEW32, 0, 1'b0, 30, 1'b1},
    '{vec_types_pkg::VOP_ADD, 3, 4, 5, 0,  vec_types_pkg::SEW8,  0, 1'b0, 0,  1'b0}
  };

  logic CLK;
  logic nRST;
  logic issue;
  vec_types_pkg::vop_t    op;
  vec_types_pkg::vreg_t   vd;
  vec_types_pkg::vreg_t   vs1;
  vec_types_pkg::vreg_t   vs2;
  vec_types_pkg::offset_t avl;
  vec_types_pkg::sew_t    sew_in;
  logic resume;
  logic stall;
  logic vstart_we;
  vec_types_pkg::offset_t vstart_in;
  logic host_we;
  vec_types_pkg::vreg_t   host_reg;
  vec_types_pkg::offset_t host_idx;
  vec_types_pkg::elem_t   host_wdata;
  vec_types_pkg::elem_t   host_rdata;
  logic busy;
  logic done;
  vec_types_pkg::offset_t vl;
  vec_types_pkg::sew_t    sew;
  vec_types_pkg::offset_t vstart;

  // Reference copy of the register file kept byte by byte with element 0 in the low bytes
  logic [7:0] model_bytes [`VEC_NUM_REGS][REG_BYTES];
  int model_sew; // 0, 1 or 2 for 8, 16 or 32 bit elements
  int errors;
  int checks;

  vec_seq_top i_dut (.*);

  initial CLK = 1'b0;
  always #(PERIOD / 2) CLK = ~CLK;

  // ========================================
  // Reference model
  // ========================================

  function automatic logic [31:0] model_read(int r, int idx);
    logic [31:0] v;
    int          w;
    w = 1 << model_sew;
    v = '0; // Narrow elements come back zero-extended
    for (int b = 0; b < w; b++) v[8 * b +: 8] = model_bytes[r][idx * w + b];
    return v;
  endfunction

  function automatic void model_write(int r, int idx, logic [31:0] v);
    int w;
    w = 1 << model_sew;
    for (int b = 0; b < w; b++) model_bytes[r][idx * w + b] = v[8 * b +: 8]; // Upper bits drop
  endfunction

  function automatic logic [31:0] expected_result(vec_types_pkg::vop_t o, logic [31:0] a,
                                                  logic [31:0] b);
    logic [31:0] mask;
    logic [31:0] res;
    mask = (model_sew == 2) ? 32'hffff_ffff : ((32'h1 << (8 << model_sew)) - 32'h1);
    case (o)
      vec_types_pkg::VOP_ADD: res = a + b;
      vec_types_pkg::VOP_SUB: res = a - b; // Borrow wraps within the element
      vec_types_pkg::VOP_AND: res = a & b;
      default:                res = a | b;
    endcase
    return res & mask;
  endfunction

  // ========================================
  // Checking and host port helpers
  // ========================================

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic host_write(int r, int idx, logic [31:0] data);
    @(negedge CLK);
    host_we    = 1'b1; // Written on the next rising edge
    host_reg   = r;
    host_idx   = idx;
    host_wdata = data;
    model_write(r, idx, data);
  endtask

  // Host read is combinational, so sample a quarter period after driving the address
  task automatic read_check(int r, int idx, logic [31:0] exp);
    @(negedge CLK);
    host_reg = r;
    host_idx = idx;
    #(PERIOD / 4);
    check_value($sformatf("v%0d[%0d]", r, idx), host_rdata, exp);
  endtask

  task automatic check_reset();
    check_value("vl", vl, 0);
    check_value("sew", sew, vec_types_pkg::SEW8);
    check_value("vstart", vstart, 0);
    check_value("busy", busy, 0);
    check_value("done", done, 0);
    for (int r = 0; r < `VEC_NUM_REGS; r++) begin
      for (int i = 0; i < REG_BYTES; i++) read_check(r, i, 0);
    end
  endtask

  task automatic set_vl(row_t rw);
    int cap;
    int exp_vl;
    cap    = REG_BYTES >> int'(rw.sew); // Capacity at the chosen width
    exp_vl = (rw.avl < cap) ? rw.avl : cap;
    @(negedge CLK);
    issue  = 1'b1;
    op     = vec_types_pkg::VOP_SETVL;
    avl    = rw.avl;
    sew_in = rw.sew;
    @(negedge CLK);
    issue = 1'b0;
    check_value("done", done, 1); // Pulse in the cycle after the sampling edge
    check_value("busy", busy, 0);
    check_value("vl", vl, exp_vl);
    check_value("sew", sew, rw.sew);
    @(negedge CLK);
    check_value("done", done, 0);
    check_value("busy", busy, 0);
    model_sew = int'(rw.sew);
  endtask

  // Fresh random contents for both sources and the destination
  task automatic load_regs(row_t rw);
    for (int i = 0; i < (REG_BYTES >> model_sew); i++) begin
      host_write(rw.vs1, i, $urandom);
      host_write(rw.vs2, i, $urandom);
      host_write(rw.vd, i, $urandom);
    end
    @(negedge CLK);
    host_we = 1'b0;
  endtask

  task automatic run_element_op(row_t rw);
    int start;
    int vl_now;
    int n;
    vl_now = int'(vl);
    if (rw.resume) begin
      @(negedge CLK);
      vstart_we = 1'b1;
      vstart_in = rw.vstart;
      @(negedge CLK);
      vstart_we = 1'b0;
      check_value("vstart", vstart, rw.vstart);
    end
    start = rw.resume ? rw.vstart : 0;
    for (int i = start; i < vl_now; i++) begin // Tail past vl stays as loaded
      model_write(rw.vd, i, expected_result(rw.op, model_read(rw.vs1, i), model_read(rw.vs2, i)));
    end
    @(negedge CLK);
    issue  = 1'b1;
    op     = rw.op;
    vd     = rw.vd;
    vs1    = rw.vs1;
    vs2    = rw.vs2;
    resume = rw.resume;
    @(negedge CLK);
    check_value("busy", busy, 1);
    n = 0;
    while (!done) begin
      issue = rw.reissue && (n == 0); // A vsetvl that must be ignored
      op     = issue ? vec_types_pkg::VOP_SETVL : rw.op;
      avl    = 1;
      sew_in = vec_types_pkg::SEW8;
      stall  = ($urandom % 100) < rw.stall_pct;
      n++;
      @(negedge CLK);
    end
    issue  = 1'b0;
    stall  = 1'b0;
    resume = 1'b0;
    check_value("busy", busy, 0); // Falls on the same edge that raises done
    check_value("vstart", vstart, 0);
    check_value("vl", vl, vl_now);
    @(negedge CLK);
    check_value("done", done, 0);
  endtask

  task automatic check_vd(int r);
    for (int i = 0; i < (REG_BYTES >> model_sew); i++) read_check(r, i, model_read(r, i));
  endtask

  // ========================================
  // Main sequence and watchdog
  // ========================================

  initial begin
    void'($urandom(32'h01c0b62a));
    nRST       = 1'b0;
    issue      = 1'b0;
    op         = vec_types_pkg::VOP_SETVL;
    vd         = '0;
    vs1        = '0;
    vs2        = '0;
    avl        = '0;
    sew_in     = vec_types_pkg::SEW8;
    resume     = 1'b0;
    stall      = 1'b0;
    vstart_we  = 1'b0;
    vstart_in  = '0;
    host_we    = 1'b0;
    host_reg   = '0;
    host_idx   = '0;
    host_wdata = '0;
    errors     = 0;
    checks     = 0;
    model_sew  = 0;
    for (int r = 0; r < `VEC_NUM_REGS; r++) begin
      for (int b = 0; b < REG_BYTES; b++) model_bytes[r][b] = 8'h00;
    end
    repeat (4) @(negedge CLK);
    nRST = 1'b1;
    check_reset();
    for (int r = 0; r < NUM_ROWS; r++) begin
      set_vl(rows[r]);
      load_regs(rows[r]);
      run_element_op(rows[r]);
      check_vd(rows[r].vd);
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Errors found");
    $finish;
  end

endmodule

/* vec_seq.f */
+incdir+hdl
hdl/vec_types_pkg.sv
hdl/element_counter_if.sv
hdl/lane_if.sv
hdl/element_counter.sv
hdl/vec_csr.sv
hdl/vec_seq_ctrl.sv
hdl/vec_lane_alu.sv
hdl/vec_regfile.sv
hdl/vec_seq_top.sv
bench/vec_seq_tb.sv
